//--- Makefile
# Verilator build of the peripheral subsystem testbench
# override any variable on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/periph_tb.sv
`timescale 1ns/10ps

module periph_tb
    import periph_pkg::*;
();

    localparam int N_LED         = 40;
    localparam int N_SW          = 12;
    localparam int N_UNMAP       = 16;
    localparam int SETTLE        = 4;      // synchronizer plus flag
    localparam int BLINK_SAMPLES = 4 * BLINK_PERIOD_CYC;
    localparam int N_TXN         = 20 + N_LED * 3 + N_SW * 3 + N_UNMAP * 8;
    localparam int CYC_LIMIT     = N_TXN * 10 + 2 * BLINK_SAMPLES + N_SW * SETTLE + 20;

    logic  clk_i;
    logic  rst_i;
    logic  req_i;
    logic  we_i;
    addr_t addr_i;
    data_t wdata_i;
    sw_t   sw_i;
    logic  ack_o;
    data_t rdata_o;
    led_t  led_o;

    logic [31:0] lfsr_q = 32'h6fe6_816b;
    int          cyc_cnt = 0;

    // reference model state
    led_t led_val_m;
    logic led_mode_m;
    sw_t  sw_m;

    periph_sb_top DUT (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (req_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .sw_i    (sw_i),
        .ack_o   (ack_o),
        .rdata_o (rdata_o),
        .led_o   (led_o)
    );

    bind sb_bus_port periph_tb_assert u_assert (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .ack_o     (ack_o),
        .led_stb_o (led_stb_o),
        .sw_stb_o  (sw_stb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt > CYC_LIMIT) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout: run went past %0d cycles", CYC_LIMIT);
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // full four-phase cycle entered and left 1 ns after an edge
    task automatic bus_xfer(input logic wr, input addr_t addr, input data_t wdata,
                            output data_t rdata);
        int          edges;
        logic [31:0] hold;
        req_i   = 1'b1;
        we_i    = wr;
        addr_i  = addr;
        wdata_i = wdata;
        edges   = 0;
        while (!ack_o && edges < 10) begin
            @(posedge clk_i);
            #1;
            edges++;
        end
        check(32'(edges), 32'd3, "edges from req to ack");
        rdata = rdata_o;
        hold = rand_bits(2);       // random back-pressure
        repeat (hold) begin
            @(posedge clk_i);
            #1;
            check(32'(ack_o), 32'd1, "ack held under back-pressure");
            check(rdata_o, rdata, "rdata held under back-pressure");
        end
        req_i = 1'b0;
        @(posedge clk_i);
        #1;
        check(32'(ack_o), 32'd0, "ack one edge after req fell");
        we_i    = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
    endtask

    task automatic write_reg(input logic [7:0] dev, input logic [7:0] ofs, input data_t data);
        data_t unused;
        bus_xfer(1'b1, {dev, 16'h0000, ofs}, data, unused);
    endtask

    task automatic read_reg(input logic [7:0] dev, input logic [7:0] ofs, output data_t data);
        bus_xfer(1'b0, {dev, 16'h0000, ofs}, rand_bits(32), data);
    endtask

    task automatic check_led_state();
        data_t d;
        read_reg(DEV_LED, LED_VAL_OFS, d);
        check(d, 32'(led_val_m), "led value readback");
        read_reg(DEV_LED, LED_MODE_OFS, d);
        check(d, 32'(led_mode_m), "led mode readback");
        if (!led_mode_m) begin
            check(32'(led_o), 32'(led_val_m), "led pins in steady mode");
        end
    endtask

    task automatic check_sw_state();
        data_t d;
        read_reg(DEV_SW, SW_VAL_OFS, d);
        check(d, 32'(sw_m), "switch value readback");
        read_reg(DEV_SW, SW_CHG_OFS, d);
        check(d, 32'd0, "change flag without a change");
    endtask

    task automatic test_led_regs();
        data_t data;
        for (int i = 0; i < N_LED; i++) begin
            if (rand_bits(1) == 1) begin
                if (rand_bits(1) == 1) begin
                    data = rand_bits(16);
                end else begin
                    data = rand_bits(32) | (32'h1 << (16 + rand_bits(4)));  // too wide
                end
                write_reg(DEV_LED, LED_VAL_OFS, data);
                if (data[31:16] == 16'h0) led_val_m = data[15:0];
            end else begin
                if (rand_bits(1) == 1) begin
                    data = rand_bits(1);
                end else begin
                    data = rand_bits(32) | 32'h2;   // not 0 or 1
                end
                write_reg(DEV_LED, LED_MODE_OFS, data);
                if (data < 32'd2) led_mode_m = data[0];
            end
            check_led_state();
        end
    endtask

    task automatic test_soft_reset();
        data_t data;
        led_val_m = led_t'(rand_bits(16)) | 16'h0001;
        write_reg(DEV_LED, LED_VAL_OFS, 32'(led_val_m));
        led_mode_m = 1'b0;
        write_reg(DEV_LED, LED_MODE_OFS, 32'd0);
        data = rand_bits(32);
        if (data == 32'd1) data = 32'd3;
        write_reg(DEV_LED, LED_RST_OFS, data);     // anything but 1 is ignored
        check_led_state();
        write_reg(DEV_LED, LED_MODE_OFS, 32'd1);
        write_reg(DEV_LED, LED_RST_OFS, 32'd1);
        led_val_m  = '0;
        led_mode_m = 1'b0;
        check_led_state();
        check(32'(led_o), 32'd0, "led pins after soft reset");
    endtask

    task automatic test_blink();
        led_t samples [BLINK_SAMPLES];
        int   start;
        led_t exp;
        led_val_m = led_t'(rand_bits(16)) | 16'h0100;
        write_reg(DEV_LED, LED_VAL_OFS, 32'(led_val_m));
        led_mode_m = 1'b1;
        write_reg(DEV_LED, LED_MODE_OFS, 32'd1);
        for (int i = 0; i < BLINK_SAMPLES; i++) begin
            samples[i] = led_o;
            idle_cycles(1);
        end
        start = -1;
        for (int i = BLINK_PERIOD_CYC; i >= 1; i--) begin
            if (samples[i - 1] == '0 && samples[i] == led_val_m) start = i;
        end
        if (start < 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "blink: led pins never switched on within one period");
        end
        for (int k = 0; k < 2 * BLINK_PERIOD_CYC; k++) begin
            exp = ((k % BLINK_PERIOD_CYC) < BLINK_ON_CYC) ? led_val_m : '0;
            check(32'(samples[start + k]), 32'(exp), "blink pattern");
        end
        check_led_state();
        led_mode_m = 1'b0;
        write_reg(DEV_LED, LED_MODE_OFS, 32'd0);
        check_led_state();
    endtask

    task automatic test_switches();
        data_t d;
        sw_t   nxt;
        logic  exp_chg;
        for (int i = 0; i < N_SW; i++) begin
            nxt = sw_t'(rand_bits(16));
            if (i % 4 == 3) nxt = sw_m;     // a round with no change
            exp_chg = (nxt != sw_m);
            sw_i = nxt;
            sw_m = nxt;
            idle_cycles(SETTLE);
            read_reg(DEV_SW, SW_VAL_OFS, d);
            check(d, 32'(sw_m), "switch value");
            read_reg(DEV_SW, SW_CHG_OFS, d);
            check(d, 32'(exp_chg), "change flag");
            read_reg(DEV_SW, SW_CHG_OFS, d);
            check(d, 32'd0, "change flag after read");
        end
    endtask

    task automatic test_unmapped();
        logic [7:0] dev;
        logic [7:0] ofs;
        data_t      data;
        data_t      d;
        logic       wr;
        led_val_m = led_t'(rand_bits(16)) | 16'h8000;
        write_reg(DEV_LED, LED_VAL_OFS, 32'(led_val_m));
        for (int i = 0; i < N_UNMAP; i++) begin
            dev = 8'(rand_bits(8));
            if (dev == DEV_LED || dev == DEV_SW) dev = dev ^ 8'h80;
            ofs  = (rand_bits(1) == 1) ? LED_RST_OFS : 8'(rand_bits(8));
            data = (rand_bits(1) == 1) ? 32'd1 : rand_bits(32);
            wr   = 1'(rand_bits(1));
            bus_xfer(wr, {dev, 8'(rand_bits(8)), 8'h00, ofs}, data, d);
            if (!wr) check(d, 32'd0, "unmapped read data");
            check_led_state();
            check_sw_state();
        end
    endtask

    initial begin
        rst_i      = 1'b1;
        req_i      = 1'b0;
        we_i       = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        sw_i       = '0;
        led_val_m  = '0;
        led_mode_m = 1'b0;
        sw_m       = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check(32'(ack_o), 32'd0, "ack after reset");
        check(rdata_o, 32'd0, "rdata after reset");
        check(32'(led_o), 32'd0, "led pins after reset");
        check_led_state();
        check_sw_state();
        test_led_regs();
        test_soft_reset();
        test_blink();
        test_switches();
        test_unmapped();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- bench/periph_tb_assert.sv
`timescale 1ns/10ps

module periph_tb_assert (
    input logic clk_i,
    input logic rst_i,
    input logic req_i,
    input logic ack_o,
    input logic led_stb_o,
    input logic sw_stb_o
);

    // ack may only rise while the master holds req
    ack_rise_with_req: assert property (
        @(posedge clk_i) disable iff (rst_i) $rose(ack_o) |-> $past(req_i)
    ) else $error("ack_o rose while req_i was low");

    // ack holds under back-pressure until req is seen low
    ack_hold: assert property (
        @(posedge clk_i) disable iff (rst_i) (ack_o && req_i) |=> ack_o
    ) else $error("ack_o dropped while req_i was still high");

    ack_release: assert property (
        @(posedge clk_i) disable iff (rst_i) (ack_o && !req_i) |=> !ack_o
    ) else $error("ack_o stayed high after req_i fell");

    one_strobe: assert property (
        @(posedge clk_i) disable iff (rst_i) !(led_stb_o && sw_stb_o)
    ) else $error("both device strobes high");

    led_stb_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i) led_stb_o |=> !led_stb_o
    ) else $error("led strobe longer than one cycle");

    sw_stb_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i) sw_stb_o |=> !sw_stb_o
    ) else $error("switch strobe longer than one cycle");

endmodule

//--- compile.f
rtl/periph_pkg.sv
rtl/sb_bus_port.sv
rtl/led_sb_ctrl.sv
rtl/sw_sb_ctrl.sv
rtl/periph_sb_top.sv
bench/periph_tb_assert.sv
bench/periph_tb.sv

//--- rtl/led_sb_ctrl.sv
`timescale 1ns/10ps

module led_sb_ctrl
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  logic [7:0] ofs_i,
    input  data_t      wdata_i,
    output data_t      rdata_o,
    output led_t       led_o
);

    led_t             led_q;
    logic             mode_q;       // 1 = blink
    logic [CNT_W-1:0] cnt_q;

    logic wr;
    logic rd;
    logic val_we;
    logic mode_we;
    logic soft_rst;
    logic cnt_wrap;

    assign wr = stb_i & we_i;
    assign rd = stb_i & ~we_i;

    // value only accepted when it fits in 16 bits
    assign val_we   = wr && (ofs_i == LED_VAL_OFS) && (wdata_i[31:16] == '0);
    assign mode_we  = wr && (ofs_i == LED_MODE_OFS) && (wdata_i[31:1] == '0);
    assign soft_rst = wr && (ofs_i == LED_RST_OFS) && (wdata_i == data_t'(1));

    assign cnt_wrap = (cnt_q == CNT_W'(BLINK_PERIOD_CYC - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i || soft_rst) begin
            led_q <= '0;
        end else if (val_we) begin
            led_q <= wdata_i[15:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || soft_rst) begin
            mode_q <= 1'b0;
        end else if (mode_we) begin
            mode_q <= wdata_i[0];
        end
    end

    // counter only runs in blink mode
    always_ff @(posedge clk_i) begin
        if (rst_i || soft_rst || !mode_q) begin
            cnt_q <= '0;
        end else if (cnt_wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // lit for the first part of each period, steady when mode is 0
    assign led_o = (cnt_q < CNT_W'(BLINK_ON_CYC)) ? led_q : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (rd) begin
            case (ofs_i)
                LED_VAL_OFS:  rdata_o <= data_t'(led_q);
                LED_MODE_OFS: rdata_o <= data_t'(mode_q);
                default:      rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- rtl/periph_pkg.sv
package periph_pkg;

    // bus side widths
    typedef logic [31:0] addr_t;    // one word
    typedef logic [31:0] data_t;

    // peripheral side widths
    typedef logic [15:0] led_t;     // half word
    typedef logic [15:0] sw_t;

    typedef enum logic [1:0] {
        IDLE,                       // waiting for req
        STROBE,                     // device strobed this cycle
        RESP,                       // device read data registered
        DONE                        // ack high until req drops
    } port_state_t;

    // device select from the upper address byte
    localparam logic [7:0] DEV_LED = 8'h01;
    localparam logic [7:0] DEV_SW  = 8'h02;

    // led controller register offsets in the low address byte
    localparam logic [7:0] LED_VAL_OFS  = 8'h00;
    localparam logic [7:0] LED_MODE_OFS = 8'h04;
    localparam logic [7:0] LED_RST_OFS  = 8'h24;

    // switch controller register offsets
    localparam logic [7:0] SW_VAL_OFS = 8'h00;
    localparam logic [7:0] SW_CHG_OFS = 8'h04;

    // Blink timing in clock cycles. These are short for simulation;
    // a board build needs values in the millions and a wider counter.
    localparam int BLINK_ON_CYC     = 10;   // leds lit for this many cycles
    localparam int BLINK_PERIOD_CYC = 20;   // full blink period
    localparam int CNT_W            = 5;    // must hold BLINK_PERIOD_CYC - 1

endpackage

//--- rtl/periph_sb_top.sv
`timescale 1ns/10ps

module periph_sb_top
    import periph_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  req_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    input  sw_t   sw_i,
    output logic  ack_o,
    output data_t rdata_o,
    output led_t  led_o
);

    logic       led_stb;
    logic       sw_stb;
    logic       we;         // shared by both devices
    logic [7:0] ofs;
    data_t      wdata;
    data_t      led_rdata;
    data_t      sw_rdata;

    sb_bus_port u_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .led_stb_o   (led_stb),
        .sw_stb_o    (sw_stb),
        .we_o        (we),
        .ofs_o       (ofs),
        .wdata_o     (wdata),
        .led_rdata_i (led_rdata),
        .sw_rdata_i  (sw_rdata)
    );

    led_sb_ctrl u_led (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stb_i   (led_stb),
        .we_i    (we),
        .ofs_i   (ofs),
        .wdata_i (wdata),
        .rdata_o (led_rdata),
        .led_o   (led_o)
    );

    sw_sb_ctrl u_sw (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stb_i   (sw_stb),
        .we_i    (we),
        .ofs_i   (ofs),
        .sw_i    (sw_i),
        .rdata_o (sw_rdata)
    );

endmodule

//--- rtl/sb_bus_port.sv
`timescale 1ns/10ps

module sb_bus_port
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    // four-phase system bus side
    input  logic       req_i,
    input  logic       we_i,
    input  addr_t      addr_i,
    input  data_t      wdata_i,
    output logic       ack_o,
    output data_t      rdata_o,

    // peripheral side
    output logic       led_stb_o,
    output logic       sw_stb_o,
    output logic       we_o,
    output logic [7:0] ofs_o,
    output data_t      wdata_o,
    input  data_t      led_rdata_i,
    input  data_t      sw_rdata_i
);

    port_state_t state_q;
    logic [7:0]  dev_q;         // latched device byte
    logic        led_sel;
    logic        sw_sel;

    assign led_sel = (dev_q == DEV_LED);
    assign sw_sel  = (dev_q == DEV_SW);

    assign led_stb_o = (state_q == STROBE) && led_sel;
    assign sw_stb_o  = (state_q == STROBE) && sw_sel;
    assign ack_o     = (state_q == DONE);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        state_q <= STROBE;
                    end
                end
                STROBE:  state_q <= RESP;
                RESP:    state_q <= DONE;   // ack rises here
                DONE: begin
                    if (!req_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request held for the rest of the cycle
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i) begin
            dev_q   <= addr_i[31:24];
            ofs_o   <= addr_i[7:0];
            we_o    <= we_i;
            wdata_o <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (state_q == RESP) begin
            if (we_o) begin
                rdata_o <= '0;              // writes return nothing
            end else if (led_sel) begin
                rdata_o <= led_rdata_i;
            end else if (sw_sel) begin
                rdata_o <= sw_rdata_i;
            end else begin
                rdata_o <= '0;              // unmapped device
            end
        end
    end

endmodule

//--- rtl/sw_sb_ctrl.sv
`timescale 1ns/10ps

module sw_sb_ctrl
    import periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  logic [7:0] ofs_i,
    input  sw_t        sw_i,
    output data_t      rdata_o
);

    sw_t  sync1_q;
    sw_t  sync2_q;
    sw_t  prev_q;       // sync2 one cycle back
    logic chg_q;

    logic rd;
    logic chg_rd;
    logic changed;

    assign rd      = stb_i & ~we_i;         // writes have no effect
    assign chg_rd  = rd && (ofs_i == SW_CHG_OFS);
    assign changed = (sync2_q != prev_q);

    // two-flop synchronizer for the asynchronous switch pins
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= sw_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    // sticky change flag where a new change beats the clear
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            chg_q <= 1'b0;
        end else if (changed) begin
            chg_q <= 1'b1;
        end else if (chg_rd) begin
            chg_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (rd) begin
            case (ofs_i)
                SW_VAL_OFS: rdata_o <= data_t'(sync2_q);
                SW_CHG_OFS: rdata_o <= data_t'(chg_q);  // value before the clear
                default:    rdata_o <= '0;
            endcase
        end
    end

endmodule
